// ==== design/cpu_port_pkg.sv ====
`default_nettype none

package cpu_port_pkg;

	//////////////////////////////
	// cpu output ports
	//////////////////////////////

	// menu mode select, data is a menu_mode_e code
	localparam logic [7:0] PORT_MODE = 8'h0B;
	// message slot select, codes 00 to 04
	localparam logic [7:0] PORT_SLOT = 8'h0C;
	// one volume step per write
	localparam logic [7:0] PORT_VOL = 8'h04;
	// recording on or off
	localparam logic [7:0] PORT_REC = 8'h05;

	//////////////////////////////
	// cpu input ports
	//////////////////////////////

	// switches in the low nibble
	localparam logic [7:0] IN_SWITCHES = 8'h00;
	// buttons, one per port, in bit 0
	localparam logic [7:0] IN_SCROLL_UP = 8'h06;
	localparam logic [7:0] IN_SCROLL_DOWN = 8'h07;
	localparam logic [7:0] IN_SELECT = 8'h08;
	localparam logic [7:0] IN_BACK = 8'h09;
	localparam logic [7:0] IN_PAUSE_PLAY = 8'h0A;
	// sequencer status flags
	localparam logic [7:0] IN_MSG_EXISTS = 8'h0B;
	localparam logic [7:0] IN_DEL_FINISH = 8'h0F;

	//////////////////////////////
	// command codes
	//////////////////////////////

	// data written to PORT_VOL
	localparam logic [7:0] VOL_CODE_UP = 8'h01;
	localparam logic [7:0] VOL_CODE_DOWN = 8'h02;
	// data written to PORT_REC, anything else turns recording off
	localparam logic [7:0] REC_CODE_ON = 8'h01;

endpackage

`default_nettype wire

// ==== design/recorder_pkg.sv ====
`default_nettype none

package recorder_pkg;

	//////////////////////////////
	// sizes
	//////////////////////////////

	// ram word address
	localparam int ADDR_W = 26;
	// one audio sample per ram word
	localparam int SAMPLE_W = 16;
	// message slots, all the same size
	localparam int SLOT_COUNT = 5;

	// volume range, level 1 is quietest
	localparam logic [3:0] VOL_MIN = 4'd1;
	localparam logic [3:0] VOL_MAX = 4'd15;
	localparam logic [3:0] VOL_RESET = 4'd1;

	//////////////////////////////
	// menu
	//////////////////////////////

	// codes as the cpu writes them to PORT_MODE
	typedef enum logic [7:0] {
		MODE_MAIN = 8'h00,
		MODE_PLAY = 8'h01,
		MODE_RECORD = 8'h02,
		MODE_DELONE = 8'h03,
		MODE_DELALL = 8'h04,
		MODE_VOL = 8'h05
	} menu_mode_e;

	// menu state seen by the sequencer and the read mux
	typedef struct packed {
		menu_mode_e mode;
		logic [2:0] slot;
		logic recording;
		// single cycle, new PORT_MODE write
		logic mode_write;
	} menu_cmd_t;

	//////////////////////////////
	// ram port
	//////////////////////////////

	typedef struct packed {
		logic [ADDR_W-1:0] address;
		logic [SAMPLE_W-1:0] wdata;
		logic write_enable;
		logic read_request;
		logic read_ack;
	} ram_req_t;

	typedef struct packed {
		logic [SAMPLE_W-1:0] rdata;
		// held by the ram until read_ack
		logic data_present;
		logic ready;
	} ram_rsp_t;

	// front panel buttons, levels
	typedef struct packed {
		logic scroll_up;
		logic scroll_down;
		logic select;
		logic back;
		logic pause_play;
	} buttons_t;

endpackage

`default_nettype wire

// ==== design/menu_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module menu_regs (
	input wire clk2,
	input wire pb_reset,
	input wire [7:0] port_id,
	input wire [7:0] out_port,
	input wire write_strobe,
	output recorder_pkg::menu_cmd_t cmd,
	output logic [3:0] volume
);
	import cpu_port_pkg::*;
	import recorder_pkg::*;

	//////////////////////////////
	// output port decode
	//////////////////////////////

	logic mode_wr;
	logic slot_wr;
	logic vol_wr;
	logic rec_wr;
	logic mode_code_ok;
	logic slot_code_ok;
	logic slot_mode;

	// one strobe per port
	assign mode_wr = write_strobe && (port_id == PORT_MODE);
	assign slot_wr = write_strobe && (port_id == PORT_SLOT);
	assign vol_wr = write_strobe && (port_id == PORT_VOL);
	assign rec_wr = write_strobe && (port_id == PORT_REC);

	// mode codes run 00 to 05
	assign mode_code_ok = (out_port <= 8'(MODE_VOL));
	// slot codes run 00 to 04
	assign slot_code_ok = (out_port < 8'(SLOT_COUNT));

	// only the slot based modes take a slot write
	assign slot_mode = (cmd.mode == MODE_PLAY) ||
		(cmd.mode == MODE_RECORD) ||
		(cmd.mode == MODE_DELONE);

	//////////////////////////////
	// command registers
	//////////////////////////////

	always_ff @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			cmd <= '{mode: MODE_MAIN, slot: 3'd0, recording: 1'b0, mode_write: 1'b0};
		end else begin
			// pulse lines up with the new mode value
			cmd.mode_write <= mode_wr;
			if (mode_wr && mode_code_ok) begin
				cmd.mode <= menu_mode_e'(out_port);
			end
			// slot held across mode changes
			if (slot_wr && slot_mode && slot_code_ok) begin
				cmd.slot <= out_port[2:0];
			end
			// recording flag only moves in record mode
			if (rec_wr && (cmd.mode == MODE_RECORD)) begin
				cmd.recording <= (out_port == REC_CODE_ON);
			end
		end
	end

	//////////////////////////////
	// volume level
	//////////////////////////////

	// one step per write, clamps at both ends
	always_ff @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			volume <= VOL_RESET;
		end else if (vol_wr && (cmd.mode == MODE_VOL)) begin
			if ((out_port == VOL_CODE_UP) && (volume < VOL_MAX)) begin
				volume <= volume + 4'd1;
			end else if ((out_port == VOL_CODE_DOWN) && (volume > VOL_MIN)) begin
				volume <= volume - 4'd1;
			end
		end
	end

	// cpu never issues back to back mode writes
	a_mode_write_pulse: assert property (@(posedge clk2) disable iff (pb_reset)
		cmd.mode_write |=> !cmd.mode_write);

endmodule

`default_nettype wire

// ==== design/ram_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram_sequencer #(
	parameter logic [recorder_pkg::ADDR_W-1:0] SLOT_WORDS = 26'h333333
) (
	input wire clk2,
	input wire pb_reset,
	input wire recorder_pkg::menu_cmd_t cmd,
	input wire recorder_pkg::ram_rsp_t ram_rsp,
	input wire [recorder_pkg::SAMPLE_W-1:0] audio_in,
	output recorder_pkg::ram_req_t ram_req,
	output logic [recorder_pkg::SAMPLE_W-1:0] audio_out,
	output logic audio_valid,
	output logic playback,
	output logic message_exists,
	output logic delete_finish
);
	import recorder_pkg::*;

	// words in all five slots together
	localparam logic [ADDR_W-1:0] MEM_WORDS = ADDR_W'(SLOT_COUNT * SLOT_WORDS);

	// waiting states: S_PLAY S_RECORD S_DELONE S_DELALL S_VOL
	typedef enum logic [3:0] {
		S_MAIN,
		S_PLAY,
		S_PLAY_WAIT,
		S_PLAY_ACK,
		S_RECORD,
		S_REC_STEP,
		S_REC_GAP,
		S_DELONE,
		S_DELALL,
		S_DEL_STEP,
		S_VOL
	} seq_state_e;

	seq_state_e state;
	logic [ADDR_W-1:0] last_addr;
	logic [ADDR_W-1:0] slot_base;
	logic [ADDR_W-1:0] slot_last;
	logic mode_pending;
	logic mode_req;
	logic del_all;
	logic take_word;

	//////////////////////////////
	// slot range
	//////////////////////////////

	// slot is sampled when main starts the transfer
	assign slot_base = ADDR_W'(cmd.slot) * SLOT_WORDS;
	assign slot_last = slot_base + SLOT_WORDS - ADDR_W'(1);

	// a mode write can land while ready is low, keep it until main takes it
	assign mode_req = mode_pending || cmd.mode_write;

	always_ff @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			mode_pending <= 1'b0;
		end else begin
			mode_pending <= mode_req && !(ram_rsp.ready && (state == S_MAIN));
		end
	end

	// word returned by the ram and not dropped by an abort
	assign take_word = ram_rsp.ready && (state == S_PLAY_WAIT) &&
		ram_rsp.data_present && !mode_req;

	// sample register, loaded with the audio_valid pulse
	always_ff @(posedge clk2) begin
		if (take_word) begin
			audio_out <= ram_rsp.rdata;
		end
	end

	assign playback = (state == S_PLAY) || (state == S_PLAY_WAIT) || (state == S_PLAY_ACK);

	//////////////////////////////
	// transfer fsm
	//////////////////////////////

	always_ff @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			state <= S_MAIN;
			ram_req <= '0;
			last_addr <= '0;
			del_all <= 1'b0;
			audio_valid <= 1'b0;
			message_exists <= 1'b0;
			delete_finish <= 1'b0;
		end else begin
			// strobes drop after one cycle
			ram_req.write_enable <= 1'b0;
			ram_req.read_request <= 1'b0;
			ram_req.read_ack <= 1'b0;
			audio_valid <= 1'b0;
			// ready low holds everything else
			if (ram_rsp.ready) begin
				case (state)
					S_MAIN: begin
						if (mode_req) begin
							case (cmd.mode)
								MODE_PLAY: begin
									ram_req.address <= slot_base;
									last_addr <= slot_last;
									state <= S_PLAY;
								end
								MODE_RECORD: begin
									ram_req.address <= slot_base;
									last_addr <= slot_last;
									state <= S_RECORD;
								end
								MODE_DELONE: begin
									ram_req.address <= slot_base;
									last_addr <= slot_last;
									del_all <= 1'b0;
									delete_finish <= 1'b0;
									state <= S_DELONE;
								end
								MODE_DELALL: begin
									// slot 0 through the end of slot 4
									ram_req.address <= '0;
									last_addr <= MEM_WORDS - ADDR_W'(1);
									del_all <= 1'b1;
									delete_finish <= 1'b0;
									state <= S_DELALL;
								end
								MODE_VOL: begin
									state <= S_VOL;
								end
								default: begin
									state <= S_MAIN;
								end
							endcase
						end
					end
					// play, one read per word
					S_PLAY: begin
						if (mode_req) begin
							state <= S_MAIN;
						end else begin
							ram_req.read_request <= 1'b1;
							state <= S_PLAY_WAIT;
						end
					end
					S_PLAY_WAIT: begin
						// ack the word even on an abort, only send it out otherwise
						if (ram_rsp.data_present) begin
							ram_req.read_ack <= 1'b1;
							audio_valid <= !mode_req;
							state <= mode_req ? S_MAIN : S_PLAY_ACK;
						end
					end
					S_PLAY_ACK: begin
						if (ram_req.address == last_addr) begin
							state <= S_MAIN;
						end else begin
							ram_req.address <= ram_req.address + ADDR_W'(1);
							state <= S_PLAY;
						end
					end
					// record, one write every 3 cycles
					S_RECORD: begin
						if (mode_req) begin
							state <= S_MAIN;
						end else if (cmd.recording) begin
							ram_req.wdata <= audio_in;
							ram_req.write_enable <= 1'b1;
							state <= S_REC_STEP;
						end
					end
					S_REC_STEP: begin
						if (ram_req.address == last_addr) begin
							// slot full
							message_exists <= 1'b1;
							state <= S_MAIN;
						end else begin
							ram_req.address <= ram_req.address + ADDR_W'(1);
							state <= S_REC_GAP;
						end
					end
					S_REC_GAP: begin
						state <= S_RECORD;
					end
					// delete, zero word every 2 cycles
					// delall sits here once delete_finish is set
					S_DELONE, S_DELALL: begin
						if (mode_req) begin
							state <= S_MAIN;
						end else if (!delete_finish) begin
							ram_req.wdata <= '0;
							ram_req.write_enable <= 1'b1;
							state <= S_DEL_STEP;
						end
					end
					S_DEL_STEP: begin
						if (ram_req.address == last_addr) begin
							delete_finish <= 1'b1;
							state <= del_all ? S_DELALL : S_MAIN;
						end else begin
							ram_req.address <= ram_req.address + ADDR_W'(1);
							state <= del_all ? S_DELALL : S_DELONE;
						end
					end
					// volume lives in menu_regs, just wait for the next mode
					S_VOL: begin
						if (mode_req) begin
							state <= S_MAIN;
						end
					end
					default: begin
						state <= S_MAIN;
					end
				endcase
			end
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	a_no_rw_overlap: assert property (@(posedge clk2) disable iff (pb_reset)
		!(ram_req.read_request && ram_req.write_enable));

	// ack only for a word the ram has presented
	a_ack_after_data: assert property (@(posedge clk2) disable iff (pb_reset)
		ram_req.read_ack |-> $past(ram_rsp.data_present));

	a_addr_in_range: assert property (@(posedge clk2) disable iff (pb_reset)
		ram_req.address < MEM_WORDS);

endmodule

`default_nettype wire

// ==== design/port_read_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_read_mux (
	input wire clk2,
	input wire pb_reset,
	input wire [7:0] port_id,
	input wire [3:0] switches,
	input wire recorder_pkg::buttons_t buttons,
	input wire message_exists,
	input wire delete_finish,
	output logic [7:0] in_port
);
	import cpu_port_pkg::*;

	// single flag into bit 0
	function automatic logic [7:0] flag_byte(input logic flag);
		return {7'b000_0000, flag};
	endfunction

	//////////////////////////////
	// read selector
	//////////////////////////////

	// cpu sees the value one clock after it drives port_id
	always_ff @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			in_port <= 8'h00;
		end else begin
			case (port_id)
				// switches in the low nibble
				IN_SWITCHES: in_port <= {4'h0, switches};
				// buttons
				IN_SCROLL_UP: in_port <= flag_byte(buttons.scroll_up);
				IN_SCROLL_DOWN: in_port <= flag_byte(buttons.scroll_down);
				IN_SELECT: in_port <= flag_byte(buttons.select);
				IN_BACK: in_port <= flag_byte(buttons.back);
				IN_PAUSE_PLAY: in_port <= flag_byte(buttons.pause_play);
				// sequencer status
				IN_MSG_EXISTS: in_port <= flag_byte(message_exists);
				IN_DEL_FINISH: in_port <= flag_byte(delete_finish);
				// nothing else is mapped
				default: in_port <= 8'h00;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/voice_recorder.sv ====
`timescale 1ns/1ps
`default_nettype none

module voice_recorder #(
	parameter logic [recorder_pkg::ADDR_W-1:0] SLOT_WORDS = 26'h333333
) (
	input wire clk2,
	input wire pb_reset,
	// cpu bus
	input wire [7:0] port_id,
	input wire [7:0] out_port,
	input wire write_strobe,
	input wire read_strobe,
	// front panel
	input wire [3:0] switches,
	input wire recorder_pkg::buttons_t buttons,
	// ram and audio
	input wire recorder_pkg::ram_rsp_t ram_rsp,
	input wire [recorder_pkg::SAMPLE_W-1:0] audio_in,
	output logic [7:0] in_port,
	output recorder_pkg::ram_req_t ram_req,
	output logic [recorder_pkg::SAMPLE_W-1:0] audio_out,
	output logic audio_valid,
	output logic playback,
	output logic [3:0] volume
);
	import recorder_pkg::*;

	// read_strobe has no consumer, no input port needs a read ack

	menu_cmd_t cmd;
	logic message_exists;
	logic delete_finish;

	//////////////////////////////
	// menu registers
	//////////////////////////////

	menu_regs u_menu_regs (
		.clk2(clk2),
		.pb_reset(pb_reset),
		.port_id(port_id),
		.out_port(out_port),
		.write_strobe(write_strobe),
		.cmd(cmd),
		.volume(volume)
	);

	//////////////////////////////
	// ram sequencer
	//////////////////////////////

	ram_sequencer #(
		.SLOT_WORDS(SLOT_WORDS)
	) u_ram_sequencer (
		.clk2(clk2),
		.pb_reset(pb_reset),
		.cmd(cmd),
		.ram_rsp(ram_rsp),
		.audio_in(audio_in),
		.ram_req(ram_req),
		.audio_out(audio_out),
		.audio_valid(audio_valid),
		.playback(playback),
		.message_exists(message_exists),
		.delete_finish(delete_finish)
	);

	//////////////////////////////
	// cpu read data
	//////////////////////////////

	port_read_mux u_port_read_mux (
		.clk2(clk2),
		.pb_reset(pb_reset),
		.port_id(port_id),
		.switches(switches),
		.buttons(buttons),
		.message_exists(message_exists),
		.delete_finish(delete_finish),
		.in_port(in_port)
	);

endmodule

`default_nettype wire

// ==== tests/tb_voice_recorder.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_voice_recorder;
	import cpu_port_pkg::*;
	import recorder_pkg::*;

	localparam int SLOT_W = 8;
	localparam int MEM_N = SLOT_COUNT * SLOT_W;
	localparam int TIMEOUT = 300;

	logic clk2;
	logic pb_reset;
	logic [7:0] port_id;
	logic [7:0] out_port;
	logic write_strobe;
	logic read_strobe;
	logic [3:0] switches;
	buttons_t buttons;
	ram_rsp_t ram_rsp;
	logic [SAMPLE_W-1:0] audio_in;
	logic [7:0] in_port;
	ram_req_t ram_req;
	logic [SAMPLE_W-1:0] audio_out;
	logic audio_valid;
	logic playback;
	logic [3:0] volume;

	// ram contents and the reference copy
	logic [15:0] ram_mem [0:63];
	logic [15:0] model_mem [0:63];
	logic [3:0] model_vol;
	logic [31:0] stim_lfsr;
	logic [31:0] ram_lfsr;
	int rd_delay;
	int errors;
	int timeouts;
	int rec_slot;
	int other_slot;

	voice_recorder #(.SLOT_WORDS(26'd8)) UUT (
		.clk2(clk2), .pb_reset(pb_reset), .port_id(port_id), .out_port(out_port),
		.write_strobe(write_strobe), .read_strobe(read_strobe), .switches(switches),
		.buttons(buttons), .ram_rsp(ram_rsp), .audio_in(audio_in), .in_port(in_port),
		.ram_req(ram_req), .audio_out(audio_out), .audio_valid(audio_valid),
		.playback(playback), .volume(volume)
	);

	always #10 clk2 = ~clk2;

	//////////////////////////////
	// random numbers
	//////////////////////////////

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one step per bit taken
	function automatic logic [31:0] stim_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = lfsr_step(stim_lfsr);
			v = {v[30:0], stim_lfsr[0]};
		end
		return v;
	endfunction

	// separate stream for the ram model
	function automatic logic [31:0] ram_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			ram_lfsr = lfsr_step(ram_lfsr);
			v = {v[30:0], ram_lfsr[0]};
		end
		return v;
	endfunction

	//////////////////////////////
	// ram model
	//////////////////////////////

	// answers reads 1 to 4 cycles late, drops ready about 1 cycle in 4
	always @(negedge clk2) begin
		if (!pb_reset) begin
			if (ram_req.write_enable) begin
				ram_mem[ram_req.address[5:0]] = ram_req.wdata;
			end
			if (ram_req.read_ack) begin
				ram_rsp.data_present = 1'b0;
			end
			if (ram_req.read_request) begin
				rd_delay = 1 + int'(ram_bits(2));
			end else if (rd_delay > 0) begin
				rd_delay = rd_delay - 1;
				if (rd_delay == 0) begin
					ram_rsp.rdata = ram_mem[ram_req.address[5:0]];
					ram_rsp.data_present = 1'b1;
				end
			end
			ram_rsp.ready = (ram_bits(2) != 32'd0);
		end
	end

	//////////////////////////////
	// cpu bus and checks
	//////////////////////////////

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		timeouts++;
	endtask

	// strobe high for one cycle, registers settled on return
	task automatic cpu_write(input logic [7:0] port, input logic [7:0] data);
		@(negedge clk2);
		port_id = port;
		out_port = data;
		write_strobe = 1'b1;
		@(negedge clk2);
		write_strobe = 1'b0;
	endtask

	// in_port is registered, one clock late
	task automatic cpu_read(input logic [7:0] port, output logic [7:0] data);
		@(negedge clk2);
		port_id = port;
		@(negedge clk2);
		data = in_port;
	endtask

	task automatic poll_port(input logic [7:0] port, input logic [7:0] value, input string what);
		logic [7:0] d;
		int t;
		t = 0;
		d = ~value;
		while (d != value && t < TIMEOUT) begin
			cpu_read(port, d);
			t++;
		end
		if (d != value) begin
			report_timeout(what);
		end
	endtask

	// slot only moves in a slot mode, play is the harmless one
	task automatic select_slot(input logic [7:0] mode, input int slot);
		cpu_write(PORT_MODE, MODE_PLAY);
		cpu_write(PORT_SLOT, 8'(slot));
		cpu_write(PORT_MODE, MODE_MAIN);
		cpu_write(PORT_MODE, mode);
	endtask

	//////////////////////////////
	// scenarios
	//////////////////////////////

	task automatic read_ports();
		logic [7:0] d;
		for (int k = 0; k < 4; k++) begin
			switches = 4'(stim_bits(4));
			buttons = 5'(stim_bits(5));
			cpu_read(IN_SWITCHES, d);
			check("in_port switches", 32'(d), 32'({4'h0, switches}));
			cpu_read(IN_SCROLL_UP, d);
			check("in_port scroll_up", 32'(d), 32'(buttons.scroll_up));
			cpu_read(IN_SCROLL_DOWN, d);
			check("in_port scroll_down", 32'(d), 32'(buttons.scroll_down));
			cpu_read(IN_SELECT, d);
			check("in_port select", 32'(d), 32'(buttons.select));
			cpu_read(IN_BACK, d);
			check("in_port back", 32'(d), 32'(buttons.back));
			cpu_read(IN_PAUSE_PLAY, d);
			check("in_port pause_play", 32'(d), 32'(buttons.pause_play));
			cpu_read(8'h33, d);
			check("in_port unmapped", 32'(d), 32'd0);
		end
		cpu_read(IN_MSG_EXISTS, d);
		check("in_port message_exists", 32'(d), 32'd0);
	endtask

	// sample held until its write shows up
	task automatic record_slot(input int slot);
		int t;
		select_slot(MODE_RECORD, slot);
		audio_in = 16'(stim_bits(16));
		cpu_write(PORT_REC, REC_CODE_ON);
		for (int i = 0; i < SLOT_W; i++) begin
			t = 0;
			while (!ram_req.write_enable && t < TIMEOUT) begin
				@(negedge clk2);
				t++;
			end
			if (!ram_req.write_enable) begin
				report_timeout("record write");
				return;
			end
			check("ram_req.address", 32'(ram_req.address), 32'(slot * SLOT_W + i));
			check("ram_req.wdata", 32'(ram_req.wdata), 32'(audio_in));
			model_mem[6'(slot * SLOT_W + i)] = audio_in;
			audio_in = 16'(stim_bits(16));
			@(negedge clk2);
		end
		cpu_write(PORT_REC, 8'h00);
		poll_port(IN_MSG_EXISTS, 8'h01, "message_exists");
	endtask

	// words below take_n are checked, take_n under SLOT_W aborts there
	task automatic play_check(input int slot, input int take_n);
		int got;
		int t;
		select_slot(MODE_PLAY, slot);
		got = 0;
		t = 0;
		while (got < take_n && t < TIMEOUT) begin
			@(negedge clk2);
			t++;
			if (audio_valid) begin
				check("audio_out", 32'(audio_out), 32'(model_mem[6'(slot * SLOT_W + got)]));
				check("playback", 32'(playback), 32'd1);
				got++;
				t = 0;
			end
		end
		if (got < take_n) begin
			report_timeout("audio_valid");
		end
		if (take_n < SLOT_W) begin
			cpu_write(PORT_MODE, MODE_MAIN);
		end
		// nothing more may come out
		got = 0;
		for (int c = 0; c < 40; c++) begin
			@(negedge clk2);
			if (audio_valid) begin
				got++;
			end
		end
		check("audio_valid after end", 32'(got), 32'd0);
		check("playback", 32'(playback), 32'd0);
	endtask

	task automatic delete_one(input int slot);
		select_slot(MODE_DELONE, slot);
		poll_port(IN_DEL_FINISH, 8'h00, "delete_finish low");
		poll_port(IN_DEL_FINISH, 8'h01, "delete_finish high");
		for (int i = 0; i < SLOT_W; i++) begin
			model_mem[6'(slot * SLOT_W + i)] = 16'h0000;
		end
	endtask

	task automatic delete_all();
		cpu_write(PORT_MODE, MODE_DELALL);
		poll_port(IN_DEL_FINISH, 8'h00, "delete_finish low");
		poll_port(IN_DEL_FINISH, 8'h01, "delete_finish high");
		for (int i = 0; i < MEM_N; i++) begin
			model_mem[6'(i)] = 16'h0000;
		end
		cpu_write(PORT_MODE, MODE_MAIN);
	endtask

	// up about 5 writes in 8
	task automatic volume_steps(input int n, input logic active);
		logic up;
		for (int k = 0; k < n; k++) begin
			up = (stim_bits(3) < 32'd5);
			cpu_write(PORT_VOL, up ? VOL_CODE_UP : VOL_CODE_DOWN);
			if (active && up && model_vol < 4'd15) begin
				model_vol = model_vol + 4'd1;
			end else if (active && !up && model_vol > 4'd1) begin
				model_vol = model_vol - 4'd1;
			end
			check("volume", 32'(volume), 32'(model_vol));
		end
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		clk2 = 1'b0;
		pb_reset = 1'b1;
		port_id = 8'h00;
		out_port = 8'h00;
		write_strobe = 1'b0;
		read_strobe = 1'b0;
		switches = 4'h0;
		buttons = '0;
		ram_rsp = '0;
		audio_in = '0;
		stim_lfsr = 32'h693e_195f;
		ram_lfsr = 32'h693e_195f;
		rd_delay = 0;
		errors = 0;
		timeouts = 0;
		model_vol = 4'd1;
		// fill from the whole address
		for (int i = 0; i < 64; i++) begin
			ram_mem[i] = 16'h5a00 ^ (16'(i) * 16'h0e35);
			model_mem[i] = ram_mem[i];
		end
		repeat (5) @(posedge clk2);
		@(negedge clk2);
		pb_reset = 1'b0;
		check("volume after reset", 32'(volume), 32'd1);

		read_ports();
		rec_slot = int'(stim_bits(3)) % SLOT_COUNT;
		other_slot = (rec_slot + 1) % SLOT_COUNT;
		record_slot(rec_slot);
		play_check(rec_slot, SLOT_W);
		play_check(other_slot, SLOT_W);
		delete_one(rec_slot);
		// the other slots keep their words
		for (int i = 0; i < MEM_N; i++) begin
			check("ram word", 32'(ram_mem[i]), 32'(model_mem[i]));
		end
		play_check(rec_slot, SLOT_W);
		play_check(other_slot, SLOT_W);
		// abort part way through
		play_check(other_slot, 3);

		cpu_write(PORT_MODE, MODE_VOL);
		volume_steps(40, 1'b1);
		cpu_write(PORT_MODE, MODE_MAIN);
		volume_steps(10, 1'b0);

		delete_all();
		for (int i = 0; i < MEM_N; i++) begin
			check("ram word", 32'(ram_mem[i]), 32'(model_mem[i]));
		end

		$display("checks done: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== voice_recorder.f ====
design/cpu_port_pkg.sv
design/recorder_pkg.sv
design/menu_regs.sv
design/ram_sequencer.sv
design/port_read_mux.sv
design/voice_recorder.sv
tests/tb_voice_recorder.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the voice recorder testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f voice_recorder.f \
	--top-module tb_voice_recorder -o sim_tb > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
grep -q "TEST PASS" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
